// File: design/mipsCore_config.svh
`ifndef MIPS_CORE_CONFIG_SVH
`define MIPS_CORE_CONFIG_SVH

// ==========================================================================
// core build options
// ==========================================================================

// first fetch address out of reset
`define MIPS_RESET_PC 32'h0000_0000

// general purpose registers, r0 reads as zero
`define MIPS_REG_COUNT 32

// data path and address width
`define MIPS_XLEN 32

`endif

// File: design/mipsPkg.sv
`include "mipsCore_config.svh"

package mipsPkg;

	typedef logic [`MIPS_XLEN-1:0] word_t;
	typedef logic [$clog2(`MIPS_REG_COUNT)-1:0] regAddr_t;

	// primary opcode field
	typedef enum logic [5:0] {
		opRtype = 6'h00,
		opJ     = 6'h02,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddiu = 6'h09,
		opOri   = 6'h0d,
		opLui   = 6'h0f,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcode_t;

	// funct field of r-type
	typedef enum logic [5:0] {
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnSlt  = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluLui
	} aluOp_t;

	// all zero is a bubble
	typedef struct packed {
		logic   regWrite;
		logic   memToReg;
		logic   memRead;
		logic   memWrite;
		logic   aluSrcImm;
		logic   regDstRd;
		logic   zeroExt;
		aluOp_t aluOp;
	} ctrl_t;

	typedef enum logic [1:0] {
		fwdReg,
		fwdMem,
		fwdWb
	} fwdSel_t;

	// ======================================================================
	// stage boundary payloads
	// ======================================================================

	typedef struct packed {
		word_t pc;
		word_t instr;
	} decStage_t;

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    srcA;
		word_t    srcB;
		word_t    imm;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
	} exStage_t;

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    aluOut;
		word_t    storeData;
		regAddr_t writeReg;
	} memStage_t;

	typedef struct packed {
		logic     regWrite;
		logic     memToReg;
		word_t    aluOut;
		word_t    loadData;
		regAddr_t writeReg;
	} wbStage_t;

	// ======================================================================
	// apb data port and retire trace
	// ======================================================================

	typedef struct packed {
		logic  psel;
		logic  penable;
		logic  pwrite;
		word_t paddr;
		word_t pwdata;
	} apbReq_t;

	typedef struct packed {
		word_t prdata;
		logic  pready;
	} apbRsp_t;

	typedef struct packed {
		logic     valid;
		regAddr_t regIdx;
		word_t    data;
	} wbInfo_t;

endpackage

// File: design/pipeReg.sv
module pipeReg #(
	parameter type payload_t = mipsPkg::decStage_t
) (
	input  logic     clk,
	input  logic     rstN,
	input  logic     en,
	input  logic     clr,
	input  payload_t d,
	output payload_t q
);

	// zero payload carries no control bits, so it retires as a bubble
	always_ff @(posedge clk) begin
		if (!rstN || clr) begin
			q <= '0;
		end else if (en) begin
			q <= d;
		end
	end

endmodule

// File: design/decoder.sv
module decoder (
	input  mipsPkg::word_t instr,
	output mipsPkg::ctrl_t ctrl,
	output logic           branch,
	output logic           bne,
	output logic           jump
);

	mipsPkg::opcode_t opcode;
	mipsPkg::funct_t  funct;

	assign opcode = mipsPkg::opcode_t'(instr[31:26]);
	assign funct  = mipsPkg::funct_t'(instr[5:0]);

	always_comb begin
		ctrl   = '0;
		branch = 1'b0;
		bne    = 1'b0;
		jump   = 1'b0;
		case (opcode)
			mipsPkg::opRtype: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDstRd = 1'b1;
				case (funct)
					mipsPkg::fnAddu: ctrl.aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSubu: ctrl.aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd:  ctrl.aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr:   ctrl.aluOp = mipsPkg::aluOr;
					mipsPkg::fnSlt:  ctrl.aluOp = mipsPkg::aluSlt;
					// nop and unsupported funct
					default:         ctrl = '0;
				endcase
			end
			mipsPkg::opAddiu: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp     = mipsPkg::aluAdd;
			end
			mipsPkg::opOri: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.zeroExt   = 1'b1;
				ctrl.aluOp     = mipsPkg::aluOr;
			end
			mipsPkg::opLui: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp     = mipsPkg::aluLui;
			end
			mipsPkg::opLw: begin
				ctrl.regWrite  = 1'b1;
				ctrl.memToReg  = 1'b1;
				ctrl.memRead   = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp     = mipsPkg::aluAdd;
			end
			mipsPkg::opSw: begin
				ctrl.memWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp     = mipsPkg::aluAdd;
			end
			// branches only steer the pc, no register write
			mipsPkg::opBeq: branch = 1'b1;
			mipsPkg::opBne: begin
				branch = 1'b1;
				bne    = 1'b1;
			end
			mipsPkg::opJ: jump = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

// File: design/aluUnit.sv
module aluUnit (
	input  mipsPkg::aluOp_t aluOp,
	input  mipsPkg::word_t  a,
	input  mipsPkg::word_t  b,
	output mipsPkg::word_t  y
);

	mipsPkg::word_t diff;
	logic           lessThan;

	assign diff = a - b;

	// signed compare from the operand signs and the difference
	always_comb begin
		if (a[31] != b[31]) begin
			lessThan = a[31];
		end else begin
			lessThan = diff[31];
		end
	end

	always_comb begin
		case (aluOp)
			mipsPkg::aluAdd: y = a + b;
			mipsPkg::aluSub: y = diff;
			mipsPkg::aluAnd: y = a & b;
			mipsPkg::aluOr:  y = a | b;
			mipsPkg::aluSlt: y = {31'h0, lessThan};
			// immediate half moves to the top
			mipsPkg::aluLui: y = {b[15:0], 16'h0000};
			default:         y = '0;
		endcase
	end

endmodule

// File: design/hazardUnit.sv
module hazardUnit (
	input  mipsPkg::regAddr_t rsD,
	input  mipsPkg::regAddr_t rtD,
	input  mipsPkg::regAddr_t rsE,
	input  mipsPkg::regAddr_t rtE,
	input  mipsPkg::regAddr_t writeRegE,
	input  mipsPkg::regAddr_t writeRegM,
	input  mipsPkg::regAddr_t writeRegW,
	input  logic              branchD,
	input  logic              regWriteE,
	input  logic              memReadE,
	input  logic              regWriteM,
	input  logic              memReadM,
	input  logic              regWriteW,
	input  logic              memBusy,
	output logic              stallF,
	output logic              stallD,
	output logic              flushE,
	output logic              forwardAD,
	output logic              forwardBD,
	output mipsPkg::fwdSel_t  forwardAE,
	output mipsPkg::fwdSel_t  forwardBE,
	output logic              hold
);

	logic lwStall;
	logic branchStall;

	// memory stage wins over writeback, r0 is never forwarded
	function automatic mipsPkg::fwdSel_t pickSource(
		input mipsPkg::regAddr_t src,
		input mipsPkg::regAddr_t regM,
		input logic              wrM,
		input mipsPkg::regAddr_t regW,
		input logic              wrW
	);
		if (src != '0 && wrM && src == regM) begin
			return mipsPkg::fwdMem;
		end else if (src != '0 && wrW && src == regW) begin
			return mipsPkg::fwdWb;
		end
		return mipsPkg::fwdReg;
	endfunction

	assign forwardAE = pickSource(rsE, writeRegM, regWriteM, writeRegW, regWriteW);
	assign forwardBE = pickSource(rtE, writeRegM, regWriteM, writeRegW, regWriteW);

	// decode compare only takes alu results from memory
	assign forwardAD = rsD != '0 && regWriteM && !memReadM && rsD == writeRegM;
	assign forwardBD = rtD != '0 && regWriteM && !memReadM && rtD == writeRegM;

	assign lwStall = memReadE && (writeRegE == rsD || writeRegE == rtD);

	always_comb begin
		branchStall = 1'b0;
		if (branchD) begin
			// result still in execute
			if (regWriteE && writeRegE != '0 && (writeRegE == rsD || writeRegE == rtD)) begin
				branchStall = 1'b1;
			end
			// load data not back yet
			if (memReadM && writeRegM != '0 && (writeRegM == rsD || writeRegM == rtD)) begin
				branchStall = 1'b1;
			end
		end
	end

	assign hold   = memBusy;
	assign stallF = lwStall || branchStall || memBusy;
	assign stallD = lwStall || branchStall || memBusy;
	// a frozen pipe keeps execute as it is
	assign flushE = (lwStall || branchStall) && !memBusy;

endmodule

// File: design/memApbMaster.sv
module memApbMaster (
	input  logic               clk,
	input  logic               rstN,
	input  mipsPkg::memStage_t req,
	input  logic               hold,
	output mipsPkg::apbReq_t   apbReq,
	input  mipsPkg::apbRsp_t   apbRsp,
	output logic               busy,
	output mipsPkg::word_t     loadData
);

	typedef enum logic {
		stSetup,
		stAccess
	} state_t;

	state_t state;
	state_t stateNext;
	logic   start;

	// a load or store sits in the memory stage
	assign start = req.ctrl.memRead || req.ctrl.memWrite;

	always_comb begin
		stateNext = state;
		case (state)
			stSetup:  if (start) stateNext = stAccess;
			stAccess: if (apbRsp.pready) stateNext = stSetup;
			default:  stateNext = stSetup;
		endcase
	end

	// the memory stage moves on in the same cycle that pready ends the access
	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stSetup;
		end else begin
			state <= stateNext;
		end
	end

	// setup phase straight from the memory stage register
	assign apbReq.psel    = (state == stAccess) || start;
	assign apbReq.penable = (state == stAccess);
	assign apbReq.pwrite  = req.ctrl.memWrite;
	assign apbReq.paddr   = {req.aluOut[31:2], 2'b00};
	assign apbReq.pwdata  = req.storeData;

	assign busy     = (state == stSetup) ? start : !apbRsp.pready;
	assign loadData = apbRsp.prdata;

endmodule

// File: design/dataPath.sv
`include "mipsCore_config.svh"

module dataPath (
	input  logic               clk,
	input  logic               rstN,
	output mipsPkg::word_t     instrAddr,
	input  mipsPkg::word_t     instr,
	input  mipsPkg::ctrl_t     ctrlD,
	input  logic               branchD,
	input  logic               bneD,
	input  logic               jumpD,
	output mipsPkg::word_t     instrD,
	input  logic               stallF,
	input  logic               stallD,
	input  logic               flushE,
	input  logic               hold,
	input  logic               forwardAD,
	input  logic               forwardBD,
	input  mipsPkg::fwdSel_t   forwardAE,
	input  mipsPkg::fwdSel_t   forwardBE,
	output mipsPkg::regAddr_t  rsD,
	output mipsPkg::regAddr_t  rtD,
	output mipsPkg::regAddr_t  rsE,
	output mipsPkg::regAddr_t  rtE,
	output mipsPkg::regAddr_t  writeRegE,
	output mipsPkg::regAddr_t  writeRegM,
	output mipsPkg::regAddr_t  writeRegW,
	output logic               regWriteE,
	output logic               memReadE,
	output logic               regWriteM,
	output logic               memReadM,
	output logic               regWriteW,
	output mipsPkg::memStage_t memReq,
	input  mipsPkg::word_t     loadData,
	input  logic               memBusy,
	output mipsPkg::wbInfo_t   wbInfo
);

	mipsPkg::decStage_t decIn, decQ;
	mipsPkg::exStage_t  exIn, exQ;
	mipsPkg::memStage_t memIn, memQ;
	mipsPkg::wbStage_t  wbIn, wbQ;

	mipsPkg::word_t pcF, pcNext, pcPlus4F;
	mipsPkg::word_t pcPlus4D, immD, rdA, rdB, srcAD, srcBD;
	mipsPkg::word_t branchTarget, jumpTarget;
	mipsPkg::word_t srcAE, srcBE, aluB, aluOutE, resultW;
	mipsPkg::word_t regFile [`MIPS_REG_COUNT];
	logic           takeBranch;

	function automatic mipsPkg::word_t pickOperand(
		input mipsPkg::fwdSel_t sel,
		input mipsPkg::word_t   fromReg,
		input mipsPkg::word_t   fromMem,
		input mipsPkg::word_t   fromWb
	);
		case (sel)
			mipsPkg::fwdMem: return fromMem;
			mipsPkg::fwdWb:  return fromWb;
			default:         return fromReg;
		endcase
	endfunction

	// ======================================================================
	// fetch
	// ======================================================================

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pcF <= `MIPS_RESET_PC;
		end else if (!stallF) begin
			pcF <= pcNext;
		end
	end

	assign instrAddr = pcF;
	assign pcPlus4F  = pcF + 32'd4;
	assign decIn     = '{pc: pcF, instr: instr};

	pipeReg #(.payload_t(mipsPkg::decStage_t)) regFD (
		.clk(clk), .rstN(rstN), .en(!stallD), .clr(1'b0), .d(decIn), .q(decQ)
	);

	// ======================================================================
	// decode, branch and jump resolve here
	// ======================================================================

	assign instrD = decQ.instr;
	assign rsD    = decQ.instr[25:21];
	assign rtD    = decQ.instr[20:16];

	// r0 reads as zero
	assign rdA = (rsD == '0) ? '0 : regFile[rsD];
	assign rdB = (rtD == '0) ? '0 : regFile[rtD];

	assign srcAD = forwardAD ? memQ.aluOut : rdA;
	assign srcBD = forwardBD ? memQ.aluOut : rdB;

	assign immD = ctrlD.zeroExt ? {16'h0000, decQ.instr[15:0]}
	                            : {{16{decQ.instr[15]}}, decQ.instr[15:0]};

	assign pcPlus4D     = decQ.pc + 32'd4;
	assign branchTarget = pcPlus4D + {immD[29:0], 2'b00};
	assign jumpTarget   = {pcPlus4D[31:28], decQ.instr[25:0], 2'b00};
	assign takeBranch   = branchD && ((srcAD == srcBD) != bneD);

	// delay slot already in fetch, so the target follows it
	assign pcNext = jumpD ? jumpTarget : (takeBranch ? branchTarget : pcPlus4F);

	always_comb begin
		if (hold) begin
			// frozen execute keeps its forwarded operands as writeback drains
			exIn      = exQ;
			exIn.srcA = srcAE;
			exIn.srcB = srcBE;
		end else begin
			exIn.ctrl = ctrlD;
			exIn.srcA = rdA;
			exIn.srcB = rdB;
			exIn.imm  = immD;
			exIn.rs   = rsD;
			exIn.rt   = rtD;
			exIn.rd   = decQ.instr[15:11];
		end
	end

	pipeReg #(.payload_t(mipsPkg::exStage_t)) regDE (
		.clk(clk), .rstN(rstN), .en(1'b1), .clr(flushE), .d(exIn), .q(exQ)
	);

	// ======================================================================
	// execute
	// ======================================================================

	assign rsE       = exQ.rs;
	assign rtE       = exQ.rt;
	assign regWriteE = exQ.ctrl.regWrite;
	assign memReadE  = exQ.ctrl.memRead;
	assign writeRegE = exQ.ctrl.regDstRd ? exQ.rd : exQ.rt;

	assign srcAE = pickOperand(forwardAE, exQ.srcA, memQ.aluOut, resultW);
	assign srcBE = pickOperand(forwardBE, exQ.srcB, memQ.aluOut, resultW);
	assign aluB  = exQ.ctrl.aluSrcImm ? exQ.imm : srcBE;

	aluUnit alu (
		.aluOp(exQ.ctrl.aluOp),
		.a    (srcAE),
		.b    (aluB),
		.y    (aluOutE)
	);

	assign memIn = '{ctrl: exQ.ctrl, aluOut: aluOutE, storeData: srcBE, writeReg: writeRegE};

	pipeReg #(.payload_t(mipsPkg::memStage_t)) regEM (
		.clk(clk), .rstN(rstN), .en(!hold), .clr(1'b0), .d(memIn), .q(memQ)
	);

	// ======================================================================
	// memory and writeback
	// ======================================================================

	assign memReq    = memQ;
	assign regWriteM = memQ.ctrl.regWrite;
	assign memReadM  = memQ.ctrl.memRead;
	assign writeRegM = memQ.writeReg;

	assign wbIn.regWrite = memQ.ctrl.regWrite;
	assign wbIn.memToReg = memQ.ctrl.memToReg;
	assign wbIn.aluOut   = memQ.aluOut;
	assign wbIn.loadData = loadData;
	assign wbIn.writeReg = memQ.writeReg;

	// bubble into writeback while the bus is waiting
	pipeReg #(.payload_t(mipsPkg::wbStage_t)) regMW (
		.clk(clk), .rstN(rstN), .en(1'b1), .clr(memBusy), .d(wbIn), .q(wbQ)
	);

	assign regWriteW = wbQ.regWrite;
	assign writeRegW = wbQ.writeReg;
	assign resultW   = wbQ.memToReg ? wbQ.loadData : wbQ.aluOut;

	// falling edge write, decode reads the new value in the same cycle
	always_ff @(negedge clk) begin
		if (wbQ.regWrite && wbQ.writeReg != '0) begin
			regFile[wbQ.writeReg] <= resultW;
		end
	end

	assign wbInfo.valid  = wbQ.regWrite && (wbQ.writeReg != '0);
	assign wbInfo.regIdx = wbQ.writeReg;
	assign wbInfo.data   = resultW;

endmodule

// File: design/mipsCore.sv
module mipsCore (
	input  logic             clk,
	input  logic             rstN,
	output mipsPkg::word_t   instrAddr,
	input  mipsPkg::word_t   instr,
	output mipsPkg::apbReq_t apbReq,
	input  mipsPkg::apbRsp_t apbRsp,
	output mipsPkg::wbInfo_t wbInfo
);

	mipsPkg::word_t     instrD, loadData;
	mipsPkg::ctrl_t     ctrlD;
	mipsPkg::memStage_t memReq;
	mipsPkg::fwdSel_t   forwardAE, forwardBE;
	mipsPkg::regAddr_t  rsD, rtD, rsE, rtE, writeRegE, writeRegM, writeRegW;
	logic branchD, bneD, jumpD;
	logic stallF, stallD, flushE, hold, forwardAD, forwardBD, memBusy;
	logic regWriteE, memReadE, regWriteM, memReadM, regWriteW;

	decoder dec (
		.instr(instrD), .ctrl(ctrlD), .branch(branchD), .bne(bneD), .jump(jumpD)
	);

	dataPath dp (
		.clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
		.ctrlD(ctrlD), .branchD(branchD), .bneD(bneD), .jumpD(jumpD), .instrD(instrD),
		.stallF(stallF), .stallD(stallD), .flushE(flushE), .hold(hold),
		.forwardAD(forwardAD), .forwardBD(forwardBD),
		.forwardAE(forwardAE), .forwardBE(forwardBE),
		.rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
		.writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
		.regWriteE(regWriteE), .memReadE(memReadE), .regWriteM(regWriteM),
		.memReadM(memReadM), .regWriteW(regWriteW),
		.memReq(memReq), .loadData(loadData), .memBusy(memBusy), .wbInfo(wbInfo)
	);

	hazardUnit hz (
		.rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
		.writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
		.branchD(branchD), .regWriteE(regWriteE), .memReadE(memReadE),
		.regWriteM(regWriteM), .memReadM(memReadM), .regWriteW(regWriteW),
		.memBusy(memBusy), .stallF(stallF), .stallD(stallD), .flushE(flushE),
		.forwardAD(forwardAD), .forwardBD(forwardBD),
		.forwardAE(forwardAE), .forwardBE(forwardBE), .hold(hold)
	);

	memApbMaster apb (
		.clk(clk), .rstN(rstN), .req(memReq), .hold(hold),
		.apbReq(apbReq), .apbRsp(apbRsp), .busy(memBusy), .loadData(loadData)
	);

endmodule

// File: verif/tbMipsCore.sv
`include "mipsCore_config.svh"

module tbMipsCore;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_WB    = 28;
	localparam int NUM_APB   = 5;
	localparam int TIMEOUT   = 3000;

	logic               clk;
	logic               rstN;
	mipsPkg::word_t     instrAddr;
	mipsPkg::word_t     instr;
	mipsPkg::apbReq_t   apbReq;
	mipsPkg::apbRsp_t   apbRsp;
	mipsPkg::wbInfo_t   wbInfo;

	mipsPkg::word_t     rom [64];
	mipsPkg::word_t     dataMem [64];
	mipsPkg::wbInfo_t   expWb [NUM_WB];
	mipsPkg::apbReq_t   expApb [NUM_APB];
	int                 wbIdx;
	int                 apbIdx;
	logic               randomWaits;
	logic [31:0]        lcgState;
	logic [1:0]         waitCnt;
	logic               inTransfer;

	mipsCore u_dut (
		.clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
		.apbReq(apbReq), .apbRsp(apbRsp), .wbInfo(wbInfo)
	);

	// combinational fetch port
	assign instr = rom[instrAddr[7:2]];

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ======================================================================
	// helpers
	// ======================================================================

	function automatic mipsPkg::word_t rType(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, 5'h00, fn};
	endfunction

	function automatic mipsPkg::word_t iType(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mipsPkg::word_t jType(input logic [25:0] target);
		return {6'h02, target};
	endfunction

	// memory fill from the whole byte address
	function automatic mipsPkg::word_t fillWord(input mipsPkg::word_t addr);
		return addr ^ 32'hc0de_0000 ^ (addr << 12);
	endfunction

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic failRun(input string line);
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkWb(input mipsPkg::wbInfo_t act, input mipsPkg::wbInfo_t exp);
		if (act !== exp) begin
			failRun($sformatf("error at %0d ns: retire r%0d=%h, expected r%0d=%h",
				$time, act.regIdx, act.data, exp.regIdx, exp.data));
		end
	endtask

	task automatic checkApb(input mipsPkg::apbReq_t act, input mipsPkg::apbReq_t exp);
		logic dataBad;
		dataBad = exp.pwrite && (act.pwdata !== exp.pwdata);
		if (act.psel !== exp.psel || act.penable !== exp.penable || act.pwrite !== exp.pwrite
			|| act.paddr !== exp.paddr || dataBad) begin
			failRun($sformatf("error at %0d ns: apb sel%b en%b wr%b %h/%h, expected wr%b %h/%h",
				$time, act.psel, act.penable, act.pwrite, act.paddr, act.pwdata,
				exp.pwrite, exp.paddr, exp.pwdata));
		end
	endtask

	// ======================================================================
	// apb slave model
	// ======================================================================

	always @(posedge clk) begin
		if (!rstN) begin
			apbRsp  <= '0;
			waitCnt <= '0;
		end else if (apbReq.psel && apbReq.penable && apbRsp.pready) begin
			if (apbReq.pwrite) begin
				dataMem[apbReq.paddr[7:2]] <= apbReq.pwdata;
			end
			apbRsp.pready <= 1'b0;
		end else if (apbReq.psel && !apbReq.penable) begin
			logic [1:0] w;
			w = 2'd0;
			if (randomWaits) begin
				lcgState = lcgNext(lcgState);
				w = lcgState[17:16];
			end
			waitCnt       <= w;
			apbRsp.pready <= (w == 2'd0);
			apbRsp.prdata <= dataMem[apbReq.paddr[7:2]];
		end else if (apbReq.psel && apbReq.penable) begin
			waitCnt       <= waitCnt - 2'd1;
			apbRsp.pready <= (waitCnt == 2'd1);
			apbRsp.prdata <= dataMem[apbReq.paddr[7:2]];
		end
	end

	// ======================================================================
	// monitors, sampled mid cycle
	// ======================================================================

	always @(negedge clk) begin
		mipsPkg::apbReq_t exp;
		if (!rstN) begin
			inTransfer = 1'b0;
			if (apbReq.psel !== 1'b0 || wbInfo.valid !== 1'b0) begin
				failRun("psel or a retire was active during reset");
			end
		end else begin
			if (wbInfo.valid) begin
				if (wbIdx >= NUM_WB) begin
					failRun($sformatf("unexpected extra retire of r%0d", wbInfo.regIdx));
				end
				checkWb(wbInfo, expWb[wbIdx]);
				wbIdx++;
			end
			if (apbReq.psel) begin
				if (apbIdx >= NUM_APB) begin
					failRun("unexpected extra apb transfer");
				end
				// one setup cycle, then access cycles until pready
				exp         = expApb[apbIdx];
				exp.penable = inTransfer;
				checkApb(apbReq, exp);
				if (apbReq.penable && apbRsp.pready) begin
					apbIdx++;
					inTransfer = 1'b0;
				end else begin
					inTransfer = 1'b1;
				end
			end else if (inTransfer) begin
				failRun("psel dropped before pready ended the apb transfer");
			end
		end
	end

	// ======================================================================
	// program and expected tables
	// ======================================================================

	task automatic setWb(input int i, input logic [4:0] r, input mipsPkg::word_t d);
		expWb[i] = '{valid: 1'b1, regIdx: r, data: d};
	endtask

	task automatic setApb(input int i, input logic wr, input mipsPkg::word_t a,
		input mipsPkg::word_t d);
		expApb[i] = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: a, pwdata: d};
	endtask

	task automatic loadProgram();
		foreach (rom[i]) rom[i] = '0;
		// alu chain
		rom[0]  = iType(mipsPkg::opAddiu, 0, 1, 16'd5);
		rom[1]  = iType(mipsPkg::opAddiu, 1, 2, 16'd7);
		rom[2]  = rType(2, 1, 3, mipsPkg::fnSubu);
		rom[3]  = iType(mipsPkg::opLui, 0, 4, 16'h1234);
		rom[4]  = iType(mipsPkg::opOri, 4, 4, 16'h5678);
		rom[5]  = rType(4, 2, 5, mipsPkg::fnAnd);
		rom[6]  = rType(5, 1, 6, mipsPkg::fnOr);
		rom[7]  = rType(3, 2, 7, mipsPkg::fnSlt);
		rom[8]  = iType(mipsPkg::opAddiu, 0, 8, 16'hffff);
		rom[9]  = rType(8, 1, 9, mipsPkg::fnSlt);
		rom[10] = rType(4, 6, 10, mipsPkg::fnAddu);
		rom[11] = iType(mipsPkg::opAddiu, 0, 0, 16'd5);
		// store, load and load-use
		rom[12] = iType(mipsPkg::opAddiu, 0, 11, 16'h0040);
		rom[13] = iType(mipsPkg::opSw, 11, 10, 16'd0);
		rom[14] = iType(mipsPkg::opLw, 11, 12, 16'd0);
		rom[15] = rType(12, 1, 13, mipsPkg::fnAddu);
		rom[16] = iType(mipsPkg::opSw, 11, 13, 16'd4);
		rom[17] = iType(mipsPkg::opLw, 11, 14, 16'd8);
		// branches with delay slots
		rom[18] = iType(mipsPkg::opAddiu, 0, 15, 16'd3);
		rom[19] = iType(mipsPkg::opBeq, 15, 1, 16'd2);
		rom[20] = iType(mipsPkg::opAddiu, 0, 16, 16'd1);
		rom[21] = iType(mipsPkg::opBne, 15, 1, 16'd2);
		rom[22] = iType(mipsPkg::opAddiu, 0, 17, 16'd2);
		rom[23] = iType(mipsPkg::opAddiu, 0, 18, 16'h0099);
		rom[24] = iType(mipsPkg::opLw, 11, 19, 16'd0);
		rom[25] = iType(mipsPkg::opBeq, 19, 10, 16'd2);
		rom[26] = iType(mipsPkg::opAddiu, 0, 20, 16'd4);
		rom[27] = iType(mipsPkg::opAddiu, 0, 21, 16'h0077);
		// countdown loop, then park
		rom[28] = iType(mipsPkg::opAddiu, 0, 22, 16'd3);
		rom[29] = iType(mipsPkg::opAddiu, 0, 23, 16'd0);
		rom[30] = iType(mipsPkg::opAddiu, 22, 22, 16'hffff);
		rom[31] = rType(23, 22, 23, mipsPkg::fnAddu);
		rom[32] = iType(mipsPkg::opBne, 22, 0, 16'hfffd);
		rom[34] = jType(26'd34);
	endtask

	task automatic loadExpected();
		int k;
		int sum;
		setWb(0, 1, 32'd5);
		setWb(1, 2, 32'd12);
		setWb(2, 3, 32'd7);
		setWb(3, 4, 32'h1234_0000);
		setWb(4, 4, 32'h1234_5678);
		setWb(5, 5, 32'd8);
		setWb(6, 6, 32'd13);
		setWb(7, 7, 32'd1);
		setWb(8, 8, 32'hffff_ffff);
		setWb(9, 9, 32'd1);
		setWb(10, 10, 32'h1234_5685);
		setWb(11, 11, 32'h0000_0040);
		setWb(12, 12, 32'h1234_5685);
		setWb(13, 13, 32'h1234_568a);
		setWb(14, 14, fillWord(32'h48));
		setWb(15, 15, 32'd3);
		setWb(16, 16, 32'd1);
		setWb(17, 17, 32'd2);
		setWb(18, 19, 32'h1234_5685);
		setWb(19, 20, 32'd4);
		setWb(20, 22, 32'd3);
		setWb(21, 23, 32'd0);
		// loop unrolled, r22 counts down and r23 sums it
		k   = 22;
		sum = 0;
		for (int n = 2; n >= 0; n--) begin
			sum += n;
			setWb(k, 22, n);
			setWb(k + 1, 23, sum);
			k += 2;
		end
		setApb(0, 1'b1, 32'h40, 32'h1234_5685);
		setApb(1, 1'b0, 32'h40, '0);
		setApb(2, 1'b1, 32'h44, 32'h1234_568a);
		setApb(3, 1'b0, 32'h48, '0);
		setApb(4, 1'b0, 32'h40, '0);
	endtask

	// ======================================================================
	// run sequence
	// ======================================================================

	task automatic runProgram(input logic withWaits);
		int cycles;
		foreach (dataMem[i]) dataMem[i] = fillWord(i * 4);
		randomWaits = withWaits;
		wbIdx       = 0;
		apbIdx      = 0;
		@(posedge clk);
		rstN <= 1'b0;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		if (instrAddr !== `MIPS_RESET_PC) begin
			failRun("first fetch after reset is not at the reset address");
		end
		cycles = 0;
		while (wbIdx < NUM_WB || apbIdx < NUM_APB) begin
			@(posedge clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				failRun("timed out waiting for the program to retire");
			end
		end
		// parked core must stay quiet
		cycles = 0;
		while (cycles < 20) begin
			@(posedge clk);
			cycles++;
		end
	endtask

	initial begin
		rstN        = 1'b0;
		apbRsp      = '0;
		waitCnt     = '0;
		randomWaits = 1'b0;
		inTransfer  = 1'b0;
		lcgState    = 32'ha220_3428;
		loadProgram();
		loadExpected();
		runProgram(1'b0);
		runProgram(1'b1);
		if (wbIdx != NUM_WB || apbIdx != NUM_APB) begin
			$display("retire or transfer count is off at the end of the run");
			$display("Simulation failed");
			$fatal(1);
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

// File: mipsCore.f
+incdir+design
design/mipsPkg.sv
design/pipeReg.sv
design/decoder.sv
design/aluUnit.sv
design/hazardUnit.sv
design/memApbMaster.sv
design/dataPath.sv
design/mipsCore.sv
verif/tbMipsCore.sv

// File: Bender.yml
package:
  name: mipsCore

sources:
  - include_dirs:
      - design
    files:
      - design/mipsPkg.sv
      - design/pipeReg.sv
      - design/decoder.sv
      - design/aluUnit.sv
      - design/hazardUnit.sv
      - design/memApbMaster.sv
      - design/dataPath.sv
      - design/mipsCore.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/tbMipsCore.sv
